//--- common/fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// ----------------------------------------------------------------------
// architectural widths of the FPU control unit
// ----------------------------------------------------------------------

// data word moved over the memory port
`define FPU_WORD_W 16

// memory word address
`define FPU_ADDR_W 16

// accumulator r1:r2:r3, three words
`define FPU_ACC_W 48

`endif

//--- common/fpu_pkg.sv
`include "fpu_defs.svh"

package fpu_pkg;

	// ----------------------------------------------------------------------
	// opcodes and sequencer states
	// ----------------------------------------------------------------------

	// AD/SD work on r1:r2, LF/RF move r1..r3
	typedef enum logic [1:0] {
		OP_AD,
		OP_SD,
		OP_LF,
		OP_RF
	} fpu_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_MEM_REQ,
		ST_MEM_REL,
		ST_EXEC,
		ST_DONE
	} fpu_state_e;

	// ----------------------------------------------------------------------
	// bundles on the CPU and memory ports
	// ----------------------------------------------------------------------

	typedef struct packed {
		fpu_op_e                 op;
		logic [`FPU_ADDR_W-1:0] addr;
	} fpu_job_t;

	typedef struct packed {
		logic                    write;
		logic [`FPU_ADDR_W-1:0] addr;
		logic [`FPU_WORD_W-1:0] wdata;
	} fpu_mem_cmd_t;

	// zero, minus, overflow
	typedef struct packed {
		logic z;
		logic m;
		logic v;
	} fpu_flags_t;

endpackage

//--- fpu_control/fpu_job_reg.sv
`include "fpu_defs.svh"

module fpu_job_reg (
	input  logic                    got_fp,
	input  logic                    _0_f,
	input  logic                    capture,
	input  fpu_pkg::fpu_job_t       job,
	output fpu_pkg::fpu_op_e        op,
	output logic [`FPU_ADDR_W-1:0] base_addr,
	output logic [1:0]              word_count,
	output logic                    store
);

	fpu_pkg::fpu_job_t job_q;

	// job is frozen from capture until the next one
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			job_q <= '0;
		end else if (capture) begin
			job_q <= job;
		end
	end

	assign op        = job_q.op;
	assign base_addr = job_q.addr;

	// load/store move r1..r3, arithmetic reads one 32-bit operand
	always_comb begin
		case (job_q.op)
			fpu_pkg::OP_LF,
			fpu_pkg::OP_RF: word_count = 2'd3;
			default:        word_count = 2'd2;
		endcase
	end

	// only RF writes to memory
	assign store = (job_q.op == fpu_pkg::OP_RF);

endmodule

//--- fpu_control/fpu_word_counter.sv
module fpu_word_counter (
	input  logic       got_fp,
	input  logic       _0_f,
	input  logic       load,
	input  logic       step,
	input  logic [1:0] word_count,
	output logic [1:0] index,
	output logic       last
);

	// ----------------------------------------------------------------------
	// word pointer, like the LP counter of the original unit
	// ----------------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			index <= 2'd0;
		end else if (load) begin
			index <= 2'd0;
		end else if (step) begin
			index <= index + 2'd1;
		end
	end

	// word_count comes from the job register and holds for the whole job,
	// so the last word is compared against it directly
	assign last = (index == word_count - 2'd1);

endmodule

//--- fpu_control/fpu_sequencer.sv
`include "fpu_defs.svh"

module fpu_sequencer (
	input  logic                    got_fp,
	input  logic                    _0_f,
	input  logic                    job_req,
	output logic                    job_ack,
	input  fpu_pkg::fpu_op_e        op,
	input  logic [`FPU_ADDR_W-1:0] base_addr,
	input  logic                    store,
	input  logic                    last,
	input  logic [1:0]              index,
	input  logic [`FPU_WORD_W-1:0] acc_word,
	output logic                    capture,
	output logic                    load,
	output logic                    step,
	output logic                    word_we,
	output logic                    exec,
	output logic                    mem_req,
	input  logic                    mem_ack,
	output fpu_pkg::fpu_mem_cmd_t   mem_cmd,
	output fpu_pkg::fpu_state_e     state
);

	fpu_pkg::fpu_state_e state_d;
	logic                mem_req_d;
	logic                arith;

	assign arith = (op == fpu_pkg::OP_AD) || (op == fpu_pkg::OP_SD);

	// index only moves in ST_MEM_REL, so the command holds while mem_req is up
	always_comb begin
		mem_cmd.write = store;
		mem_cmd.addr  = base_addr + {{(`FPU_ADDR_W-2){1'b0}}, index};
		mem_cmd.wdata = store ? acc_word : '0;
	end

	// ----------------------------------------------------------------------
	// next state and one-cycle pulses
	// ----------------------------------------------------------------------

	always_comb begin
		state_d   = state;
		mem_req_d = mem_req;
		capture   = 1'b0;
		load      = 1'b0;
		step      = 1'b0;
		word_we   = 1'b0;
		exec      = 1'b0;
		case (state)
			fpu_pkg::ST_IDLE: begin
				if (job_req) begin
					capture = 1'b1;
					load    = 1'b1;
					state_d = fpu_pkg::ST_MEM_REQ;
				end
			end
			fpu_pkg::ST_MEM_REQ: begin
				if (!mem_req) begin
					// previous word fully released before the next request
					if (!mem_ack)
						mem_req_d = 1'b1;
				end else if (mem_ack) begin
					word_we   = !store;
					mem_req_d = 1'b0;
					state_d   = fpu_pkg::ST_MEM_REL;
				end
			end
			fpu_pkg::ST_MEM_REL: begin
				if (!mem_ack) begin
					step = 1'b1;
					if (!last)
						state_d = fpu_pkg::ST_MEM_REQ;
					else if (arith)
						state_d = fpu_pkg::ST_EXEC;
					else
						state_d = fpu_pkg::ST_DONE;
				end
			end
			fpu_pkg::ST_EXEC: begin
				exec    = 1'b1;
				state_d = fpu_pkg::ST_DONE;
			end
			fpu_pkg::ST_DONE: begin
				// wait for the CPU to drop its request
				if (!job_req)
					state_d = fpu_pkg::ST_IDLE;
			end
			default: state_d = fpu_pkg::ST_IDLE;
		endcase
	end

	// ----------------------------------------------------------------------
	// state and handshake registers
	// ----------------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state   <= fpu_pkg::ST_IDLE;
			mem_req <= 1'b0;
			job_ack <= 1'b0;
		end else begin
			state   <= state_d;
			mem_req <= mem_req_d;
			job_ack <= (state_d == fpu_pkg::ST_DONE);
		end
	end

endmodule

//--- design/fpu_accumulator.sv
`include "fpu_defs.svh"

module fpu_accumulator (
	input  logic                    got_fp,
	input  logic                    _0_f,
	input  fpu_pkg::fpu_op_e        op,
	input  logic [1:0]              index,
	input  logic                    word_we,
	input  logic [`FPU_WORD_W-1:0] rdata,
	input  logic                    exec,
	output logic [`FPU_WORD_W-1:0] acc_word,
	output fpu_pkg::fpu_flags_t     flags
);

	// acc holds r1 in the top word, r3 in the bottom one
	logic [`FPU_ACC_W-1:0]     acc;
	logic [2*`FPU_WORD_W-1:0] opnd;
	logic [2*`FPU_WORD_W-1:0] lhs;
	logic [2*`FPU_WORD_W-1:0] res;
	logic                      sub;
	logic                      ovf;

	// ----------------------------------------------------------------------
	// 32-bit add/subtract on r1:r2
	// ----------------------------------------------------------------------

	assign lhs = acc[`FPU_ACC_W-1 -: 2*`FPU_WORD_W];
	assign sub = (op == fpu_pkg::OP_SD);
	assign res = sub ? lhs - opnd : lhs + opnd;

	// sign of result differs from lhs while the operand sign
	// (inverted for subtract) matched it
	assign ovf = (lhs[2*`FPU_WORD_W-1] ^ res[2*`FPU_WORD_W-1]) &
		~(lhs[2*`FPU_WORD_W-1] ^ opnd[2*`FPU_WORD_W-1] ^ sub);

	// ----------------------------------------------------------------------
	// r1..r3 and flags
	// ----------------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			acc   <= '0;
			flags <= '0;
		end else if (exec) begin
			acc[`FPU_ACC_W-1 -: 2*`FPU_WORD_W] <= res;
			flags.z <= (res == '0);
			flags.m <= res[2*`FPU_WORD_W-1];
			flags.v <= ovf;
		end else if (word_we && op == fpu_pkg::OP_LF) begin
			case (index)
				2'd0:    acc[`FPU_ACC_W-1 -: `FPU_WORD_W] <= rdata;
				2'd1:    acc[`FPU_ACC_W-`FPU_WORD_W-1 -: `FPU_WORD_W] <= rdata;
				default: acc[`FPU_WORD_W-1:0] <= rdata;
			endcase
		end
	end

	// operand buffer for AD/SD, high word first
	always_ff @(posedge got_fp) begin
		if (word_we && (op == fpu_pkg::OP_AD || op == fpu_pkg::OP_SD)) begin
			if (index == 2'd0)
				opnd[2*`FPU_WORD_W-1 -: `FPU_WORD_W] <= rdata;
			else
				opnd[`FPU_WORD_W-1:0] <= rdata;
		end
	end

	// store data for RF
	always_comb begin
		case (index)
			2'd0:    acc_word = acc[`FPU_ACC_W-1 -: `FPU_WORD_W];
			2'd1:    acc_word = acc[`FPU_ACC_W-`FPU_WORD_W-1 -: `FPU_WORD_W];
			default: acc_word = acc[`FPU_WORD_W-1:0];
		endcase
	end

endmodule

//--- design/fpu_top.sv
`include "fpu_defs.svh"

module fpu_top (
	input  logic                    got_fp,
	input  logic                    _0_f,
	input  logic                    job_req,
	input  fpu_pkg::fpu_job_t       job,
	output logic                    job_ack,
	output fpu_pkg::fpu_flags_t     flags,
	output logic                    mem_req,
	output fpu_pkg::fpu_mem_cmd_t   mem_cmd,
	input  logic                    mem_ack,
	input  logic [`FPU_WORD_W-1:0] mem_rdata,
	output fpu_pkg::fpu_state_e     state
);

	fpu_pkg::fpu_op_e        op;
	logic [`FPU_ADDR_W-1:0] base_addr;
	logic [1:0]              word_count;
	logic                    store;
	logic [1:0]              index;
	logic                    last;
	logic [`FPU_WORD_W-1:0] acc_word;
	logic                    capture;
	logic                    load;
	logic                    step;
	logic                    word_we;
	logic                    exec;

	// ----------------------------------------------------------------------
	// controller
	// ----------------------------------------------------------------------

	fpu_job_reg job_reg_i (
		.got_fp     (got_fp),
		._0_f       (_0_f),
		.capture    (capture),
		.job        (job),
		.op         (op),
		.base_addr  (base_addr),
		.word_count (word_count),
		.store      (store)
	);

	fpu_word_counter word_counter_i (
		.got_fp     (got_fp),
		._0_f       (_0_f),
		.load       (load),
		.step       (step),
		.word_count (word_count),
		.index      (index),
		.last       (last)
	);

	fpu_sequencer sequencer_i (
		.got_fp    (got_fp),
		._0_f      (_0_f),
		.job_req   (job_req),
		.job_ack   (job_ack),
		.op        (op),
		.base_addr (base_addr),
		.store     (store),
		.last      (last),
		.index     (index),
		.acc_word  (acc_word),
		.capture   (capture),
		.load      (load),
		.step      (step),
		.word_we   (word_we),
		.exec      (exec),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_cmd   (mem_cmd),
		.state     (state)
	);

	// datapath
	fpu_accumulator accumulator_i (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.op       (op),
		.index    (index),
		.word_we  (word_we),
		.rdata    (mem_rdata),
		.exec     (exec),
		.acc_word (acc_word),
		.flags    (flags)
	);

endmodule

//--- verification/fpu_mem_model.sv
`include "fpu_defs.svh"

module fpu_mem_model (
	input  logic                    got_fp,
	input  logic                    mem_req,
	input  fpu_pkg::fpu_mem_cmd_t   mem_cmd,
	output logic                    mem_ack,
	output logic [`FPU_WORD_W-1:0] mem_rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [`FPU_WORD_W-1:0] mem [0:255];
	int unsigned             delay;
	int                      i;

	// fill pattern built from the whole word address
	initial begin
		mem_ack   = 1'b0;
		mem_rdata = '0;
		for (i = 0; i < 256; i++)
			mem[i] = {i[7:0], ~i[7:0]} ^ 16'h5a00;
	end

	// ack after 0 to 3 extra falling edges
	// release as soon as mem_req is seen low
	always begin
		@(negedge got_fp);
		if (mem_req && !mem_ack) begin
			delay = $urandom_range(3, 0);
			repeat (delay)
				@(negedge got_fp);
			if (mem_cmd.write)
				mem[mem_cmd.addr[7:0]] = mem_cmd.wdata;
			else
				mem_rdata = mem[mem_cmd.addr[7:0]];
			mem_ack = 1'b1;
		end else if (!mem_req && mem_ack) begin
			mem_ack = 1'b0;
		end
	end

endmodule

//--- verification/fpu_tb.sv
`include "fpu_defs.svh"

module fpu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// 22 jobs of up to about 30 cycles each plus a wide margin
	localparam int MAX_CYCLES = 4000;

	typedef logic [`FPU_WORD_W-1:0] word_t;
	typedef logic [`FPU_ADDR_W-1:0] addr_t;

	logic                  got_fp;
	logic                  _0_f;
	logic                  job_req;
	fpu_pkg::fpu_job_t     job;
	logic                  job_ack;
	fpu_pkg::fpu_flags_t   flags;
	logic                  mem_req;
	fpu_pkg::fpu_mem_cmd_t mem_cmd;
	logic                  mem_ack;
	word_t                 mem_rdata;
	fpu_pkg::fpu_state_e   state;

	// reference r1..r3 and flags
	word_t               ref_r [0:2];
	fpu_pkg::fpu_flags_t ref_flags;
	addr_t               addr_log [$];
	logic                req_seen = 1'b0;
	string               test_name = "reset";
	int                  cycles = 0;
	int                  errors = 0;
	int                  n_pass = 0;
	int                  n_fail = 0;

	fpu_top fpu_top_i (
		.got_fp    (got_fp),
		._0_f      (_0_f),
		.job_req   (job_req),
		.job       (job),
		.job_ack   (job_ack),
		.flags     (flags),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.state     (state)
	);

	fpu_mem_model mem_model_i (
		.got_fp    (got_fp),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	// ----------------------------------------------------------------------
	// clock, timeout and address monitor
	// ----------------------------------------------------------------------

	initial begin
		got_fp = 1'b0;
		forever #4 got_fp = ~got_fp;
	end

	always @(posedge got_fp) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, sequencer stuck in %s", cycles, state.name());
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// address of each memory cycle as its request rises
	always @(negedge got_fp) begin
		if (mem_req && !req_seen)
			addr_log.push_back(mem_cmd.addr);
		req_seen = mem_req;
	end

	// ----------------------------------------------------------------------
	// protocol checks
	// ----------------------------------------------------------------------

	a_req_after_release: assert property (@(posedge got_fp) disable iff (_0_f)
		$rose(mem_req) |-> !$past(mem_ack))
		else note_protocol_error("mem_req rose while mem_ack was still high");

	a_ack_needs_req: assert property (@(posedge got_fp) disable iff (_0_f)
		$rose(job_ack) |-> $past(job_req))
		else note_protocol_error("job_ack rose without job_req");

	a_cmd_stable: assert property (@(posedge got_fp) disable iff (_0_f)
		mem_req && $past(mem_req) |-> $stable(mem_cmd))
		else note_protocol_error("mem_cmd changed while mem_req was high");

	// idle means both handshakes are quiet
	a_idle_quiet: assert property (@(posedge got_fp) disable iff (_0_f)
		state == fpu_pkg::ST_IDLE |-> !mem_req && !job_ack)
		else note_protocol_error("job_ack or mem_req high while idle");

	a_ack_release: assert property (@(posedge got_fp) disable iff (_0_f)
		job_ack && !job_req |=> !job_ack)
		else note_protocol_error("job_ack still high a cycle after job_req dropped");

	task automatic note_protocol_error(input string msg);
		$display("protocol error in %s: %s", test_name, msg);
		errors++;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic end_test();
		$display("test %s: %0d error(s)", test_name, errors);
		if (errors == 0)
			n_pass++;
		else
			n_fail++;
		errors = 0;
	endtask

	function automatic word_t read_mem(input addr_t addr);
		return mem_model_i.mem[addr[7:0]];
	endfunction

	// two words high first, then a third
	task automatic preload(input addr_t base, input logic [31:0] value, input word_t third);
		mem_model_i.mem[base[7:0]]        = value[31:16];
		mem_model_i.mem[base[7:0] + 8'd1] = value[15:0];
		mem_model_i.mem[base[7:0] + 8'd2] = third;
	endtask

	// ----------------------------------------------------------------------
	// CPU driver and reference model
	// ----------------------------------------------------------------------

	// with scramble the job bus changes at random once the job is captured
	task automatic run_job(input fpu_pkg::fpu_op_e op, input addr_t base,
			input bit scramble, output fpu_pkg::fpu_flags_t seen);
		@(negedge got_fp);
		job.op   = op;
		job.addr = base;
		job_req  = 1'b1;
		while (!job_ack) begin
			@(negedge got_fp);
			if (scramble && state != fpu_pkg::ST_IDLE) begin
				job.op   = fpu_pkg::fpu_op_e'(2'($urandom));
				job.addr = addr_t'($urandom);
			end
		end
		seen    = flags;
		job_req = 1'b0;
		while (job_ack)
			@(negedge got_fp);
	endtask

	task automatic do_job(input fpu_pkg::fpu_op_e op, input addr_t base,
			input bit scramble, output fpu_pkg::fpu_flags_t seen);
		logic [31:0] lhs;
		logic [31:0] opnd;
		logic [31:0] res;
		longint      exact;
		int          nwords;
		int          i;
		lhs    = {ref_r[0], ref_r[1]};
		opnd   = {read_mem(base), read_mem(base + addr_t'(1))};
		nwords = (op == fpu_pkg::OP_LF || op == fpu_pkg::OP_RF) ? 3 : 2;
		addr_log.delete();
		run_job(op, base, scramble, seen);
		// word i of a job lives at base plus i
		check_value("word count", nwords, addr_log.size());
		for (i = 0; i < addr_log.size() && i < nwords; i++)
			check_value("address", base + addr_t'(i), addr_log[i]);
		case (op)
			fpu_pkg::OP_LF: begin
				for (i = 0; i < 3; i++)
					ref_r[i] = read_mem(base + addr_t'(i));
			end
			fpu_pkg::OP_RF: begin
				for (i = 0; i < 3; i++)
					check_value("stored word", ref_r[i], read_mem(base + addr_t'(i)));
			end
			default: begin
				if (op == fpu_pkg::OP_AD) begin
					res   = lhs + opnd;
					exact = longint'($signed(lhs)) + longint'($signed(opnd));
				end else begin
					res   = lhs - opnd;
					exact = longint'($signed(lhs)) - longint'($signed(opnd));
				end
				ref_r[0]    = res[31:16];
				ref_r[1]    = res[15:0];
				ref_flags.z = (res == 32'd0);
				ref_flags.m = res[31];
				// exact result outside the 32-bit signed range
				ref_flags.v = (exact != longint'($signed(res)));
			end
		endcase
		check_value("flags", ref_flags, seen);
	endtask

	task automatic sd_case(input logic [31:0] lhs, input logic [31:0] opnd,
			input logic [2:0] exp_flags);
		fpu_pkg::fpu_flags_t seen;
		preload(16'h0050, lhs, word_t'($urandom));
		preload(16'h0058, opnd, '0);
		do_job(fpu_pkg::OP_LF, 16'h0050, 1'b0, seen);
		do_job(fpu_pkg::OP_SD, 16'h0058, 1'b0, seen);
		check_value("expected flags", exp_flags, seen);
		do_job(fpu_pkg::OP_RF, 16'h0060, 1'b0, seen);
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------

	initial begin
		fpu_pkg::fpu_flags_t seen;
		int                  k;
		void'($urandom(90096));
		_0_f      = 1'b1;
		job_req   = 1'b0;
		job       = '0;
		ref_r     = '{default: '0};
		ref_flags = '0;
		repeat (5) @(posedge got_fp);
		@(negedge got_fp);
		_0_f = 1'b0;

		// quiet bus after reset
		repeat (4) @(negedge got_fp);
		check_value("job_ack", 0, job_ack);
		check_value("mem_req", 0, mem_req);
		check_value("flags", 0, flags);
		check_value("state", fpu_pkg::ST_IDLE, state);
		end_test();

		test_name = "lf_rf_copy";
		preload(16'h0010, $urandom, word_t'($urandom));
		do_job(fpu_pkg::OP_LF, 16'h0010, 1'b0, seen);
		do_job(fpu_pkg::OP_RF, 16'h0080, 1'b0, seen);
		for (k = 0; k < 3; k++)
			check_value("copy", read_mem(16'h0010 + addr_t'(k)), read_mem(16'h0080 + addr_t'(k)));
		end_test();

		test_name = "ad_random";
		for (k = 0; k < 3; k++) begin
			preload(16'h0020, $urandom, word_t'($urandom));
			preload(16'h0030, $urandom, word_t'($urandom));
			do_job(fpu_pkg::OP_LF, 16'h0020, 1'b0, seen);
			do_job(fpu_pkg::OP_AD, 16'h0030, 1'b0, seen);
			do_job(fpu_pkg::OP_RF, 16'h0040, 1'b0, seen);
		end
		end_test();

		// zero, negative, signed overflow
		test_name = "sd_flags";
		sd_case(32'h1234_5678, 32'h1234_5678, 3'b100);
		sd_case(32'd5, 32'd9, 3'b010);
		sd_case(32'h8000_0000, 32'd1, 3'b001);
		end_test();

		test_name = "job_bus_change";
		preload(16'h0070, $urandom, word_t'($urandom));
		do_job(fpu_pkg::OP_LF, 16'h0070, 1'b1, seen);
		do_job(fpu_pkg::OP_RF, 16'h0090, 1'b1, seen);
		end_test();

		$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- fpu_top.f
+incdir+common
common/fpu_pkg.sv
fpu_control/fpu_job_reg.sv
fpu_control/fpu_word_counter.sv
fpu_control/fpu_sequencer.sv
design/fpu_accumulator.sv
design/fpu_top.sv
verification/fpu_mem_model.sv
verification/fpu_tb.sv
